//--- design/qsim_types_pkg.sv
package qsim_types_pkg;

	// Fixed point format, two's complement parts
	localparam int PART_W    = 32;
	localparam int FRAC_BITS = 30;             // Q2.30, 1.0 = 2**30

	// Complex word is {re, im}, real part in the upper half
	localparam int CPLX_W = 2 * PART_W;

	// Partial products are kept at full width until the final shift
	localparam int PROD_W = 2 * PART_W;

	// State vector slice held by one processing element
	localparam int STATE_DEPTH = 64;
	localparam int STATE_AW    = $clog2(STATE_DEPTH);
	localparam int N_PAIRS     = STATE_DEPTH / 2; // pairs per gate application

	// Gate memory holds u00, u01, u10, u11
	localparam int GATE_DEPTH = 4;
	localparam int GATE_AW    = $clog2(GATE_DEPTH);

	// Target qubit index, 0 to STATE_AW-1 are legal
	localparam int QBIT_W = 3;

	// Complex MAC datapath
	localparam int ALU_LANES = 2;
	localparam int ALU_LAT   = 2;              // start to result, in cycles

	// Sparse applies a diagonal gate, dense a full 2x2 matrix
	typedef enum logic {
		OP_SPARSE = 1'b0,
		OP_DENSE  = 1'b1
	} op_mode_t;

endpackage

//--- design/pe_ctrl_pkg.sv
package pe_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_GATE,  // Two gate words per cycle into the core registers
		EXE,         // One pair read per cycle
		DRAIN,       // Wait for in-flight write-backs
		DONE
	} pe_state_t;

	localparam int FETCH_CYCLES = 2;
	localparam int DRAIN_CYCLES = 4;

	// Read issue to write-back distance, memory read plus operand register plus ALU
	localparam int WB_DLY = qsim_types_pkg::ALU_LAT + 2;

	// Shared sequencing counter covers fetch, pair index and drain
	localparam int SEQ_CNT_W = $clog2(qsim_types_pkg::N_PAIRS);

endpackage

//--- design/pe_controller.sv
`timescale 1ns/10ps

module pe_controller
	import qsim_types_pkg::*, pe_ctrl_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,

	input  logic                i_start,
	input  op_mode_t            i_op_mode,
	input  logic [QBIT_W-1:0]   i_target,

	// State memory, read address and write address per port
	output logic                o_state_en_a,
	output logic                o_state_we_a,
	output logic [STATE_AW-1:0] o_state_addr_a,
	output logic [STATE_AW-1:0] o_state_waddr_a,
	output logic                o_state_en_b,
	output logic                o_state_we_b,
	output logic [STATE_AW-1:0] o_state_addr_b,
	output logic [STATE_AW-1:0] o_state_waddr_b,

	// Gate memory reads
	output logic                o_gate_en,
	output logic [GATE_AW-1:0]  o_gate_addr_0,
	output logic [GATE_AW-1:0]  o_gate_addr_1,
	output logic                o_gate_cap,

	output logic                o_alu_start,
	output op_mode_t            o_mode,
	output logic                o_busy,
	output logic                o_done
);

	pe_state_t            state;
	logic [SEQ_CNT_W-1:0] cnt;
	logic [QBIT_W-1:0]    target;

	logic                rd_issue;
	logic [STATE_AW-1:0] rd_addr_a;
	logic [STATE_AW-1:0] rd_addr_b;

	logic [WB_DLY-1:0]   vld_q;          // Bit i set means a pair read i+1 cycles ago
	logic [STATE_AW-1:0] wa_q [WB_DLY];
	logic [STATE_AW-1:0] wb_q [WB_DLY];

	// Insert a zero at bit t of the pair index
	function automatic logic [STATE_AW-1:0] pair_addr(input logic [SEQ_CNT_W-1:0] k,
			input logic [QBIT_W-1:0] t);
		logic [STATE_AW-1:0] k_w;
		logic [STATE_AW-1:0] low_mask;
		k_w      = STATE_AW'(k);
		low_mask = (STATE_AW'(1) << t) - STATE_AW'(1);
		return ((k_w & ~low_mask) << 1) | (k_w & low_mask);
	endfunction

	assign rd_issue  = (state == EXE);
	assign rd_addr_a = pair_addr(cnt, target);
	assign rd_addr_b = rd_addr_a | (STATE_AW'(1) << target); // Partner has the target bit set

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			cnt    <= '0;
			target <= '0;
			o_mode <= OP_SPARSE;
		end else begin
			case (state)
				IDLE: begin
					if (i_start) begin
						state  <= FETCH_GATE;
						cnt    <= '0;
						target <= i_target;
						o_mode <= i_op_mode;
					end
				end
				FETCH_GATE: begin
					if (cnt == SEQ_CNT_W'(FETCH_CYCLES - 1)) begin
						state <= EXE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				EXE: begin
					if (cnt == SEQ_CNT_W'(N_PAIRS - 1)) begin
						state <= DRAIN;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DRAIN: begin
					if (cnt == SEQ_CNT_W'(DRAIN_CYCLES - 1))
						state <= DONE;
					else
						cnt <= cnt + 1'b1;
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Valid bits and the registered done and capture strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q      <= '0;
			o_gate_cap <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			vld_q      <= {vld_q[WB_DLY-2:0], rd_issue};
			o_gate_cap <= o_gate_en;        // Gate read data is valid one cycle later
			o_done     <= (state == DONE);
		end
	end

	// Address delay line for write-back
	always_ff @(posedge clk) begin
		wa_q[0] <= rd_addr_a;
		wb_q[0] <= rd_addr_b;
		for (int i = 1; i < WB_DLY; i++) begin
			wa_q[i] <= wa_q[i-1];
			wb_q[i] <= wb_q[i-1];
		end
	end

	assign o_state_en_a    = rd_issue;
	assign o_state_en_b    = rd_issue;
	assign o_state_addr_a  = rd_addr_a;
	assign o_state_addr_b  = rd_addr_b;
	assign o_state_we_a    = vld_q[WB_DLY-1];
	assign o_state_we_b    = vld_q[WB_DLY-1];
	assign o_state_waddr_a = wa_q[WB_DLY-1];
	assign o_state_waddr_b = wb_q[WB_DLY-1];

	// First fetch cycle reads u00/u01, second reads u10/u11
	assign o_gate_en     = (state == FETCH_GATE);
	assign o_gate_addr_0 = {cnt[0], 1'b0};
	assign o_gate_addr_1 = {cnt[0], 1'b1};

	assign o_alu_start = vld_q[WB_DLY-ALU_LAT-1]; // Operands registered two cycles after issue
	assign o_busy      = (state != IDLE);

endmodule

//--- design/pe_lsu.sv
`timescale 1ns/10ps

module pe_lsu
	import qsim_types_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_busy,

	// Outside access, shares port a while idle
	input  logic                i_ext_en,
	input  logic                i_ext_we,
	input  logic [STATE_AW-1:0] i_ext_addr,
	input  logic [CPLX_W-1:0]   i_ext_data,

	// Controller ports
	input  logic                i_en_a,
	input  logic                i_we_a,
	input  logic [STATE_AW-1:0] i_addr_a,
	input  logic [STATE_AW-1:0] i_waddr_a,
	input  logic [CPLX_W-1:0]   i_wdata_a,
	input  logic                i_en_b,
	input  logic                i_we_b,
	input  logic [STATE_AW-1:0] i_addr_b,
	input  logic [STATE_AW-1:0] i_waddr_b,
	input  logic [CPLX_W-1:0]   i_wdata_b,

	// Gate memory
	input  logic                i_gate_we,
	input  logic [GATE_AW-1:0]  i_gate_waddr,
	input  logic [CPLX_W-1:0]   i_gate_wdata,
	input  logic                i_gate_en,
	input  logic [GATE_AW-1:0]  i_gate_raddr_0,
	input  logic [GATE_AW-1:0]  i_gate_raddr_1,

	output logic [CPLX_W-1:0]   o_rdata_a,
	output logic [CPLX_W-1:0]   o_rdata_b,
	output logic [CPLX_W-1:0]   o_gate_rdata_0,
	output logic [CPLX_W-1:0]   o_gate_rdata_1
);

	logic [CPLX_W-1:0] state_mem [STATE_DEPTH];
	logic [CPLX_W-1:0] gate_mem  [GATE_DEPTH];

	// Port a after arbitration
	logic                rd_en_a;
	logic                wr_en_a;
	logic [STATE_AW-1:0] raddr_a;
	logic [STATE_AW-1:0] waddr_a;
	logic [CPLX_W-1:0]   wdata_a;

	always_comb begin
		if (i_busy) begin
			rd_en_a = i_en_a;
			wr_en_a = i_we_a;
			raddr_a = i_addr_a;
			waddr_a = i_waddr_a;
			wdata_a = i_wdata_a;
		end else begin
			rd_en_a = i_ext_en & ~i_ext_we;
			wr_en_a = i_ext_en & i_ext_we;
			raddr_a = i_ext_addr;
			waddr_a = i_ext_addr;
			wdata_a = i_ext_data;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_a)
			state_mem[waddr_a] <= wdata_a;
		if (i_busy && i_we_b)
			state_mem[i_waddr_b] <= i_wdata_b; // Port b is internal only
	end

	always_ff @(posedge clk) begin
		if (i_gate_we)
			gate_mem[i_gate_waddr] <= i_gate_wdata;
	end

	// Registered reads
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_rdata_a      <= '0;
			o_rdata_b      <= '0;
			o_gate_rdata_0 <= '0;
			o_gate_rdata_1 <= '0;
		end else begin
			if (rd_en_a)
				o_rdata_a <= state_mem[raddr_a];
			if (i_busy && i_en_b)
				o_rdata_b <= state_mem[i_addr_b];
			if (i_gate_en) begin
				o_gate_rdata_0 <= gate_mem[i_gate_raddr_0];
				o_gate_rdata_1 <= gate_mem[i_gate_raddr_1];
			end
		end
	end

endmodule

//--- design/complex_alu.sv
`timescale 1ns/10ps

module complex_alu
	import qsim_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_start,
	// Lane 0 computes x0*x1 + x2*x3, lane 1 computes x4*x5 + x6*x7
	input  logic [CPLX_W-1:0] i_x0,
	input  logic [CPLX_W-1:0] i_x1,
	input  logic [CPLX_W-1:0] i_x2,
	input  logic [CPLX_W-1:0] i_x3,
	input  logic [CPLX_W-1:0] i_x4,
	input  logic [CPLX_W-1:0] i_x5,
	input  logic [CPLX_W-1:0] i_x6,
	input  logic [CPLX_W-1:0] i_x7,
	output logic [CPLX_W-1:0] o_y0,
	output logic [CPLX_W-1:0] o_y1,
	output logic              o_valid
);

	logic [CPLX_W-1:0]        x    [4*ALU_LANES];
	logic signed [PROD_W-1:0] pp   [ALU_LANES][8]; // Stage 1 partial products
	logic [CPLX_W-1:0]        y_q  [ALU_LANES];
	logic [ALU_LAT-1:0]       vld_q;

	function automatic logic signed [PART_W-1:0] re_part(input logic [CPLX_W-1:0] c);
		return c[CPLX_W-1 -: PART_W];
	endfunction

	function automatic logic signed [PART_W-1:0] im_part(input logic [CPLX_W-1:0] c);
		return c[PART_W-1:0];
	endfunction

	// Full width signed product
	function automatic logic signed [PROD_W-1:0] mul(input logic signed [PART_W-1:0] a,
			input logic signed [PART_W-1:0] b);
		logic signed [PROD_W-1:0] a_w;
		logic signed [PROD_W-1:0] b_w;
		a_w = a;
		b_w = b;
		return a_w * b_w;
	endfunction

	// Back to Q2.30, low part only so overflow wraps
	function automatic logic [PART_W-1:0] to_fix(input logic signed [PROD_W-1:0] s);
		logic signed [PROD_W-1:0] sh;
		sh = s >>> FRAC_BITS;
		return sh[PART_W-1:0];
	endfunction

	assign x = '{i_x0, i_x1, i_x2, i_x3, i_x4, i_x5, i_x6, i_x7};

	// Term t of lane l is x[4l+2t] * x[4l+2t+1]
	always_ff @(posedge clk) begin
		for (int l = 0; l < ALU_LANES; l++) begin
			for (int t = 0; t < 2; t++) begin
				pp[l][4*t]   <= mul(re_part(x[4*l+2*t]), re_part(x[4*l+2*t+1]));
				pp[l][4*t+1] <= mul(im_part(x[4*l+2*t]), im_part(x[4*l+2*t+1]));
				pp[l][4*t+2] <= mul(re_part(x[4*l+2*t]), im_part(x[4*l+2*t+1]));
				pp[l][4*t+3] <= mul(im_part(x[4*l+2*t]), re_part(x[4*l+2*t+1]));
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < ALU_LANES; l++) begin
			y_q[l] <= {to_fix(pp[l][0] - pp[l][1] + pp[l][4] - pp[l][5]),  // re
			           to_fix(pp[l][2] + pp[l][3] + pp[l][6] + pp[l][7])}; // im
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vld_q <= '0;
		else
			vld_q <= {vld_q[ALU_LAT-2:0], i_start};
	end

	assign o_y0    = y_q[0];
	assign o_y1    = y_q[1];
	assign o_valid = vld_q[ALU_LAT-1];

endmodule

//--- design/pe_core.sv
`timescale 1ns/10ps

module pe_core
	import qsim_types_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,

	input  logic                i_start,
	input  op_mode_t            i_op_mode,
	input  logic [QBIT_W-1:0]   i_target,

	// Local memory access from outside
	input  logic                i_ldm_en,
	input  logic                i_ldm_we,
	input  logic [STATE_AW-1:0] i_ldm_addr,
	input  logic [CPLX_W-1:0]   i_ldm_data,

	// Gate load
	input  logic                i_gate_valid,
	input  logic [GATE_AW-1:0]  i_gate_addr,
	input  logic [CPLX_W-1:0]   i_gate_data,

	output logic [CPLX_W-1:0]   o_ldm_data,
	output logic                o_busy,
	output logic                o_done
);

	// Controller to memories
	logic                state_en_a, state_we_a;
	logic                state_en_b, state_we_b;
	logic [STATE_AW-1:0] state_addr_a, state_waddr_a;
	logic [STATE_AW-1:0] state_addr_b, state_waddr_b;
	logic                gate_en;
	logic [GATE_AW-1:0]  gate_addr_0, gate_addr_1;
	logic                gate_cap;
	logic                alu_start;
	op_mode_t            mode;
	logic                busy;

	// Datapath
	logic [CPLX_W-1:0] rdata_a, rdata_b;
	logic [CPLX_W-1:0] gate_rd_0, gate_rd_1;
	logic [CPLX_W-1:0] gate_q [GATE_DEPTH]; // u00, u01, u10, u11 once both captures are done
	logic [CPLX_W-1:0] x_q [8];
	logic [CPLX_W-1:0] alu_y0, alu_y1;
	logic              alu_valid;

	// Each capture shifts the older pair down, so the first pair lands in words 0 and 1
	always_ff @(posedge clk) begin
		if (gate_cap) begin
			gate_q[0] <= gate_q[2];
			gate_q[1] <= gate_q[3];
			gate_q[2] <= gate_rd_0;
			gate_q[3] <= gate_rd_1;
		end
	end

	// Operand registers, sa on port a and sb on port b
	always_ff @(posedge clk) begin
		if (mode == OP_DENSE) begin
			x_q[0] <= gate_q[0];  // u00 * sa
			x_q[1] <= rdata_a;
			x_q[2] <= gate_q[1];  // u01 * sb
			x_q[3] <= rdata_b;
			x_q[4] <= gate_q[2];  // u10 * sa
			x_q[5] <= rdata_a;
			x_q[6] <= gate_q[3];  // u11 * sb
			x_q[7] <= rdata_b;
		end else begin
			// Diagonal, second term is zero in both lanes
			x_q[0] <= gate_q[0];
			x_q[1] <= rdata_a;
			x_q[2] <= '0;
			x_q[3] <= '0;
			x_q[4] <= gate_q[1];
			x_q[5] <= rdata_b;
			x_q[6] <= '0;
			x_q[7] <= '0;
		end
	end

	pe_controller u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_start         (i_start),
		.i_op_mode       (i_op_mode),
		.i_target        (i_target),
		.o_state_en_a    (state_en_a),
		.o_state_we_a    (state_we_a),
		.o_state_addr_a  (state_addr_a),
		.o_state_waddr_a (state_waddr_a),
		.o_state_en_b    (state_en_b),
		.o_state_we_b    (state_we_b),
		.o_state_addr_b  (state_addr_b),
		.o_state_waddr_b (state_waddr_b),
		.o_gate_en       (gate_en),
		.o_gate_addr_0   (gate_addr_0),
		.o_gate_addr_1   (gate_addr_1),
		.o_gate_cap      (gate_cap),
		.o_alu_start     (alu_start),
		.o_mode          (mode),
		.o_busy          (busy),
		.o_done          (o_done)
	);

	pe_lsu u_lsu (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_busy         (busy),
		.i_ext_en       (i_ldm_en),
		.i_ext_we       (i_ldm_we),
		.i_ext_addr     (i_ldm_addr),
		.i_ext_data     (i_ldm_data),
		.i_en_a         (state_en_a),
		.i_we_a         (state_we_a & alu_valid), // Write only a finished result
		.i_addr_a       (state_addr_a),
		.i_waddr_a      (state_waddr_a),
		.i_wdata_a      (alu_y0),
		.i_en_b         (state_en_b),
		.i_we_b         (state_we_b & alu_valid),
		.i_addr_b       (state_addr_b),
		.i_waddr_b      (state_waddr_b),
		.i_wdata_b      (alu_y1),
		.i_gate_we      (i_gate_valid),
		.i_gate_waddr   (i_gate_addr),
		.i_gate_wdata   (i_gate_data),
		.i_gate_en      (gate_en),
		.i_gate_raddr_0 (gate_addr_0),
		.i_gate_raddr_1 (gate_addr_1),
		.o_rdata_a      (rdata_a),
		.o_rdata_b      (rdata_b),
		.o_gate_rdata_0 (gate_rd_0),
		.o_gate_rdata_1 (gate_rd_1)
	);

	complex_alu u_alu (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_start (alu_start),
		.i_x0    (x_q[0]),
		.i_x1    (x_q[1]),
		.i_x2    (x_q[2]),
		.i_x3    (x_q[3]),
		.i_x4    (x_q[4]),
		.i_x5    (x_q[5]),
		.i_x6    (x_q[6]),
		.i_x7    (x_q[7]),
		.o_y0    (alu_y0),
		.o_y1    (alu_y1),
		.o_valid (alu_valid)
	);

	assign o_ldm_data = rdata_a;
	assign o_busy     = busy;

endmodule

//--- bench/pe_checker.sv
`timescale 1ns/10ps

module pe_checker
	import qsim_types_pkg::*;
#(
	parameter int NAME_W = 80
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_start,
	input  op_mode_t            i_op_mode,
	input  logic [QBIT_W-1:0]   i_target,
	input  logic                i_ldm_en,
	input  logic                i_ldm_we,
	input  logic [STATE_AW-1:0] i_ldm_addr,
	input  logic [CPLX_W-1:0]   i_ldm_data,
	input  logic                i_gate_valid,
	input  logic [GATE_AW-1:0]  i_gate_addr,
	input  logic [CPLX_W-1:0]   i_gate_data,
	input  logic [CPLX_W-1:0]   i_ldm_rdata,
	input  logic                i_busy,
	input  logic [NAME_W-1:0]   i_test_name,
	output int                  o_mismatches,
	output int                  o_compared
);

	logic [CPLX_W-1:0]   model [STATE_DEPTH];
	logic [CPLX_W-1:0]   gate  [GATE_DEPTH];
	logic                pend;
	logic [STATE_AW-1:0] pend_addr;

	// u*s + v*r, four real products per part kept at 64 bits
	function automatic logic [CPLX_W-1:0] cmac(input logic [CPLX_W-1:0] u,
			input logic [CPLX_W-1:0] s, input logic [CPLX_W-1:0] v, input logic [CPLX_W-1:0] r);
		logic signed [63:0] ur, ui, sr, si, vr, vi, rr, ri;
		logic signed [63:0] re_sum, im_sum;
		ur = $signed(u[63:32]);
		ui = $signed(u[31:0]);
		sr = $signed(s[63:32]);
		si = $signed(s[31:0]);
		vr = $signed(v[63:32]);
		vi = $signed(v[31:0]);
		rr = $signed(r[63:32]);
		ri = $signed(r[31:0]);
		re_sum = (ur * sr - ui * si + vr * rr - vi * ri) >>> FRAC_BITS;
		im_sum = (ur * si + ui * sr + vr * ri + vi * rr) >>> FRAC_BITS;
		return {re_sum[31:0], im_sum[31:0]};
	endfunction

	// Every index with the target bit clear is the low half of one pair
	task automatic apply_gate(input op_mode_t mode, input logic [QBIT_W-1:0] t);
		int                b;
		logic [CPLX_W-1:0] sa, sb;
		for (int a = 0; a < STATE_DEPTH; a++) begin
			if (((a >> t) & 1) == 0) begin
				b  = a + (1 << t);
				sa = model[a];
				sb = model[b];
				if (mode == OP_DENSE) begin
					model[a] = cmac(gate[0], sa, gate[1], sb);
					model[b] = cmac(gate[2], sa, gate[3], sb);
				end else begin
					model[a] = cmac(gate[0], sa, '0, '0);
					model[b] = cmac(gate[1], sb, '0, '0);
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			o_mismatches = 0;
			o_compared   = 0;
			pend         = 1'b0;
		end else begin
			if (pend) begin   // Read issued last cycle, data is out now
				o_compared++;
				if (i_ldm_rdata !== model[pend_addr]) begin
					o_mismatches++;
					$display("FAIL %s addr %0d expected %h actual %h", i_test_name, pend_addr,
						model[pend_addr], i_ldm_rdata);
				end
			end
			pend      = i_ldm_en && !i_ldm_we && !i_busy;
			pend_addr = i_ldm_addr;
			if (i_ldm_en && i_ldm_we && !i_busy)
				model[i_ldm_addr] = i_ldm_data;
			if (i_gate_valid)
				gate[i_gate_addr] = i_gate_data;
			if (i_start && !i_busy)
				apply_gate(i_op_mode, i_target);
		end
	end

endmodule

//--- bench/tb_pe_core.sv
`timescale 1ns/10ps

module tb_pe_core
	import qsim_types_pkg::*;
;

	localparam int NAME_W      = 8 * 10;
	localparam int N_TESTS     = 8;
	localparam int DONE_LIMIT  = 64;
	localparam int CYCLE_LIMIT = N_TESTS * (64 + 4 + 40 + 66) * 2;

	// Q2.30 constants, complex word is {re, im}
	localparam logic [CPLX_W-1:0] C_ONE  = 64'h4000_0000_0000_0000;
	localparam logic [CPLX_W-1:0] C_I    = 64'h0000_0000_4000_0000;
	localparam logic [CPLX_W-1:0] C_ZERO = 64'h0;
	localparam logic [CPLX_W-1:0] C_HP   = 64'h2D41_3CCD_0000_0000; // 1/sqrt(2)
	localparam logic [CPLX_W-1:0] C_HN   = 64'hD2BE_C333_0000_0000; // -1/sqrt(2)

	logic                clk, rst_n;
	logic                start, ldm_en, ldm_we, gate_valid;
	op_mode_t            op_mode;
	logic [QBIT_W-1:0]   target;
	logic [STATE_AW-1:0] ldm_addr;
	logic [CPLX_W-1:0]   ldm_data, gate_data, ldm_rdata;
	logic [GATE_AW-1:0]  gate_addr;
	logic                busy, done;

	logic [NAME_W-1:0]   cur_name;
	int                  mismatches, compared, cycle_cnt, n_rows, n_pass, n_fail;

	// Stimulus table
	logic [NAME_W-1:0]   tbl_name   [N_TESTS];
	op_mode_t            tbl_mode   [N_TESTS];
	logic [QBIT_W-1:0]   tbl_target [N_TESTS];
	logic [CPLX_W-1:0]   tbl_gate   [N_TESTS][GATE_DEPTH];
	bit                  tbl_reload [N_TESTS];

	pe_core i_dut (
		.clk (clk), .rst_n (rst_n),
		.i_start (start), .i_op_mode (op_mode), .i_target (target),
		.i_ldm_en (ldm_en), .i_ldm_we (ldm_we), .i_ldm_addr (ldm_addr), .i_ldm_data (ldm_data),
		.i_gate_valid (gate_valid), .i_gate_addr (gate_addr), .i_gate_data (gate_data),
		.o_ldm_data (ldm_rdata), .o_busy (busy), .o_done (done)
	);

	pe_checker #(.NAME_W(NAME_W)) u_checker (
		.clk (clk), .rst_n (rst_n),
		.i_start (start), .i_op_mode (op_mode), .i_target (target),
		.i_ldm_en (ldm_en), .i_ldm_we (ldm_we), .i_ldm_addr (ldm_addr), .i_ldm_data (ldm_data),
		.i_gate_valid (gate_valid), .i_gate_addr (gate_addr), .i_gate_data (gate_data),
		.i_ldm_rdata (ldm_rdata), .i_busy (busy), .i_test_name (cur_name),
		.o_mismatches (mismatches), .o_compared (compared)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Magnitude below 0.5, so at most 2**29 - 1
	function automatic logic [PART_W-1:0] rand_part();
		int unsigned r;
		r = $urandom % 32'h3FFF_FFFF;
		return PART_W'(r) - 32'h1FFF_FFFF;
	endfunction

	function automatic logic [CPLX_W-1:0] rand_cplx();
		return {rand_part(), rand_part()};
	endfunction

	task automatic add_row(input logic [NAME_W-1:0] name, input op_mode_t mode,
			input logic [QBIT_W-1:0] tgt, input logic [CPLX_W-1:0] g0, input logic [CPLX_W-1:0] g1,
			input logic [CPLX_W-1:0] g2, input logic [CPLX_W-1:0] g3, input bit reload);
		tbl_name[n_rows]    = name;
		tbl_mode[n_rows]    = mode;
		tbl_target[n_rows]  = tgt;
		tbl_gate[n_rows][0] = g0;
		tbl_gate[n_rows][1] = g1;
		tbl_gate[n_rows][2] = g2;
		tbl_gate[n_rows][3] = g3;
		tbl_reload[n_rows]  = reload;
		n_rows++;
	endtask

	task automatic build_table();
		n_rows = 0;
		add_row("ident_t0  ", OP_DENSE, 3'd0, C_ONE, C_ZERO, C_ZERO, C_ONE, 1'b1);
		add_row("hadam_t0  ", OP_DENSE, 3'd0, C_HP, C_HP, C_HP, C_HN, 1'b1);
		add_row("hadam_t3  ", OP_DENSE, 3'd3, C_HP, C_HP, C_HP, C_HN, 1'b1);
		add_row("hadam_t5  ", OP_DENSE, 3'd5, C_HP, C_HP, C_HP, C_HN, 1'b0);
		add_row("paulix_t2 ", OP_DENSE, 3'd2, C_ZERO, C_ONE, C_ONE, C_ZERO, 1'b1);
		add_row("phase_t4  ", OP_SPARSE, 3'd4, C_ONE, C_I, rand_cplx(), rand_cplx(), 1'b1);
		add_row("rand1_t1  ", OP_DENSE, 3'd1, rand_cplx(), rand_cplx(), rand_cplx(), rand_cplx(), 1'b1);
		add_row("rand2_t4  ", OP_DENSE, 3'd4, rand_cplx(), rand_cplx(), rand_cplx(), rand_cplx(), 1'b0);
	endtask

	task automatic load_state();
		for (int a = 0; a < STATE_DEPTH; a++) begin
			@(posedge clk);
			ldm_en   <= 1'b1;
			ldm_we   <= 1'b1;
			ldm_addr <= STATE_AW'(a);
			ldm_data <= rand_cplx();
		end
		@(posedge clk);
		ldm_en <= 1'b0;
		ldm_we <= 1'b0;
	endtask

	task automatic load_gates(input int row);
		for (int g = 0; g < GATE_DEPTH; g++) begin
			@(posedge clk);
			gate_valid <= 1'b1;
			gate_addr  <= GATE_AW'(g);
			gate_data  <= tbl_gate[row][g];
		end
		@(posedge clk);
		gate_valid <= 1'b0;
	endtask

	task automatic start_op(input op_mode_t mode, input logic [QBIT_W-1:0] tgt);
		@(posedge clk);
		start   <= 1'b1;
		op_mode <= mode;
		target  <= tgt;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done(output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < DONE_LIMIT) begin
			@(negedge clk);
			seen = done;
			n++;
		end
	endtask

	task automatic read_state();
		for (int a = 0; a < STATE_DEPTH; a++) begin
			@(posedge clk);
			ldm_en   <= 1'b1;
			ldm_we   <= 1'b0;
			ldm_addr <= STATE_AW'(a);
		end
		@(posedge clk);
		ldm_en <= 1'b0;
		repeat (2) @(posedge clk);   // Last compare happens on the following negedge
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int  err_before, cmp_before, errs;
		bit  done_ok;
		rst_n      = 1'b0;
		start      = 1'b0;
		op_mode    = OP_SPARSE;
		target     = '0;
		ldm_en     = 1'b0;
		ldm_we     = 1'b0;
		ldm_addr   = '0;
		ldm_data   = '0;
		gate_valid = 1'b0;
		gate_addr  = '0;
		gate_data  = '0;
		cur_name   = "reset     ";
		n_pass     = 0;
		n_fail     = 0;
		void'($urandom(74));
		build_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		for (int t = 0; t < N_TESTS; t++) begin
			cur_name   = tbl_name[t];
			err_before = mismatches;
			cmp_before = compared;
			errs       = 0;
			if (tbl_reload[t])
				load_state();
			load_gates(t);
			start_op(tbl_mode[t], tbl_target[t]);
			wait_done(done_ok);
			if (!done_ok) begin
				$display("Test %s: no done pulse within %0d cycles of start", cur_name, DONE_LIMIT);
				errs++;
			end
			if (busy) begin
				$display("Test %s: DUT still busy when readout begins", cur_name);
				errs++;
			end
			read_state();
			if (compared - cmp_before != STATE_DEPTH) begin
				$display("Test %s: only %0d of %0d readout words were checked", cur_name,
					compared - cmp_before, STATE_DEPTH);
				errs++;
			end
			errs += mismatches - err_before;
			if (errs == 0) begin
				n_pass++;
				$display("Test %0d %s ok", t, cur_name);
			end else begin
				n_fail++;
				$display("Test %0d %s failed with %0d errors", t, cur_name, errs);
			end
		end

		$display("Summary: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- build.f
design/qsim_types_pkg.sv
design/pe_ctrl_pkg.sv
design/pe_controller.sv
design/pe_lsu.sv
design/complex_alu.sv
design/pe_core.sv
bench/pe_checker.sv
bench/tb_pe_core.sv

//--- Bender.yml
package:
  name: pe_core

sources:
  - design/qsim_types_pkg.sv
  - design/pe_ctrl_pkg.sv
  - design/pe_controller.sv
  - design/pe_lsu.sv
  - design/complex_alu.sv
  - design/pe_core.sv
  - target: simulation
    files:
      - bench/pe_checker.sv
      - bench/tb_pe_core.sv
